// File: src.f
+incdir+source
source/srt_div_pkg.sv
source/lead_zero_count.sv
source/srt_lane.sv
source/div_dispatch.sv
source/div_collect.sv
source/srt_div_unit.sv
dv/tb_clock.sv
dv/srt_div_checker.sv
dv/srt_div_tb.sv

// File: Makefile
# Verilator build and run for the divide unit testbench

VERILATOR ?= verilator
TOP       ?= srt_div_tb
FILE_LIST ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
RUN_FLAGS ?= +verilator+error+limit+100
PASS_TEXT ?= Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "run passed"; \
	else \
		echo "run failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/srt_div_tb.sv
// divide unit testbench
`timescale 1ns/10ps
`default_nettype none
`include "srt_div_macros.svh"

module srt_div_tb;

    localparam int NUM_TAGS = 1 << `TAG_WIDTH;
    localparam int TIMEOUT_CYCLES = 400;

    logic clk, reset, apply_reset;
    logic req_valid_1, req_signed_1, req_valid_2, req_signed_2;
    srt_div_pkg::tag_t req_tag_1, req_tag_2, res_tag, next_tag;
    srt_div_pkg::data_t req_dividend_1, req_divisor_1, req_dividend_2, req_divisor_2;
    logic ready_1, ready_2, res_valid, res_div_zero;
    srt_div_pkg::data_t res_quotient, res_remainder;

    // {div_zero, quotient, remainder} per tag
    logic [2*`DIV_WIDTH:0] expected [NUM_TAGS];
    int issued [NUM_TAGS] = '{default: 0};
    int returned [NUM_TAGS] = '{default: 0};
    logic [31:0] rng_state = 32'h3ad91b22;
    int value_errors = 0;
    int check_errors = 0;
    int timeouts = 0;
    int results_seen = 0;
    bit timed_out = 1'b0;

    tb_clock u_clock (.apply_reset(apply_reset), .clk(clk), .reset(reset));

    srt_div_unit u_srt_div_unit (
        .clk            (clk),
        .reset          (reset),
        .req_valid_1    (req_valid_1),
        .req_tag_1      (req_tag_1),
        .req_signed_1   (req_signed_1),
        .req_dividend_1 (req_dividend_1),
        .req_divisor_1  (req_divisor_1),
        .req_valid_2    (req_valid_2),
        .req_tag_2      (req_tag_2),
        .req_signed_2   (req_signed_2),
        .req_dividend_2 (req_dividend_2),
        .req_divisor_2  (req_divisor_2),
        .ready_1        (ready_1),
        .ready_2        (ready_2),
        .res_valid      (res_valid),
        .res_tag        (res_tag),
        .res_quotient   (res_quotient),
        .res_remainder  (res_remainder),
        .res_div_zero   (res_div_zero)
    );

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // truncating divide, remainder follows the dividend
    function automatic logic [2*`DIV_WIDTH:0] expected_result(input logic sgn,
            input srt_div_pkg::data_t a, input srt_div_pkg::data_t b);
        longint sa, sb;
        srt_div_pkg::data_t q, r;
        if (b == '0) begin
            return {1'b1, 32'hffff_ffff, a};
        end
        if (sgn && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
            return {1'b0, a, 32'h0};
        end
        if (sgn) begin
            sa = longint'($signed(a));
            sb = longint'($signed(b));
            q = srt_div_pkg::data_t'(sa / sb);
            r = srt_div_pkg::data_t'(sa % sb);
        end else begin
            q = a / b;
            r = a % b;
        end
        return {1'b0, q, r};
    endfunction

    function automatic srt_div_pkg::tag_t alloc_tag();
        srt_div_pkg::tag_t t;
        t = next_tag;
        for (int i = 0; i < NUM_TAGS; i++) begin
            if (issued[t] != returned[t]) begin
                t = t + srt_div_pkg::tag_t'(1);
            end
        end
        next_tag = t + srt_div_pkg::tag_t'(1);
        return t;
    endfunction

    function automatic int outstanding_count();
        int n;
        n = 0;
        for (int t = 0; t < NUM_TAGS; t++) begin
            if (issued[t] != returned[t]) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic random_operands(output logic sgn, output srt_div_pkg::data_t a,
            output srt_div_pkg::data_t b);
        logic [31:0] shift;
        a = next_random();
        shift = next_random();
        b = next_random() >> shift[4:0];
        // short dividends now and then
        if (shift[6]) begin
            a = a >> shift[12:8];
        end
        sgn = shift[5];
    endtask

    task automatic wait_for_ready(input bit both);
        int cycles;
        if (timed_out) begin
            return;
        end
        cycles = 0;
        @(negedge clk);
        while (!(both ? ready_2 : ready_1) && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (!(both ? ready_2 : ready_1)) begin
            timeouts++;
            timed_out = 1'b1;
            $display("timeout: the divide unit never became ready at %0t ns", $time);
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (reset && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (reset) begin
            timeouts++;
            timed_out = 1'b1;
            $display("timeout: reset was never released");
        end
    endtask

    task automatic issue_requests(input bit both,
            input logic s1, input srt_div_pkg::data_t a1, input srt_div_pkg::data_t b1,
            input logic s2, input srt_div_pkg::data_t a2, input srt_div_pkg::data_t b2);
        srt_div_pkg::tag_t t1, t2;
        wait_for_ready(both);
        if (timed_out) begin
            return;
        end
        @(posedge clk);
        t1 = alloc_tag();
        expected[t1] = expected_result(s1, a1, b1);
        issued[t1] = issued[t1] + 1;
        req_valid_1 <= 1'b1;
        req_tag_1 <= t1;
        req_signed_1 <= s1;
        req_dividend_1 <= a1;
        req_divisor_1 <= b1;
        if (both) begin
            t2 = alloc_tag();
            expected[t2] = expected_result(s2, a2, b2);
            issued[t2] = issued[t2] + 1;
            req_valid_2 <= 1'b1;
            req_tag_2 <= t2;
            req_signed_2 <= s2;
            req_dividend_2 <= a2;
            req_divisor_2 <= b2;
        end
        @(posedge clk);
        req_valid_1 <= 1'b0;
        req_valid_2 <= 1'b0;
    endtask

    task automatic issue_one(input logic s, input srt_div_pkg::data_t a,
            input srt_div_pkg::data_t b);
        issue_requests(1'b0, s, a, b, 1'b0, '0, '0);
    endtask

    task automatic drain();
        int cycles;
        if (timed_out) begin
            return;
        end
        cycles = 0;
        @(posedge clk);
        while (outstanding_count() != 0 && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (outstanding_count() != 0) begin
            timeouts++;
            timed_out = 1'b1;
            $display("timeout: %0d results never returned", outstanding_count());
        end
    endtask

    // scoreboard by tag
    always @(negedge clk) begin : compare_results
        logic [2*`DIV_WIDTH:0] want;
        if (reset) begin
            // results in flight are dropped by reset
            for (int t = 0; t < NUM_TAGS; t++) begin
                returned[t] = issued[t];
            end
        end else if (res_valid) begin
            want = expected[res_tag];
            results_seen++;
            assert (issued[res_tag] != returned[res_tag]) else begin
                value_errors++;
                $display("** Error at %0t ns: result for tag %0d which is not outstanding",
                    $time, res_tag);
            end
            assert ({res_div_zero, res_quotient, res_remainder} == want) else begin
                value_errors++;
                $display("** Error at %0t ns: tag %0d got q=%h r=%h dz=%b, want q=%h r=%h dz=%b",
                    $time, res_tag, res_quotient, res_remainder, res_div_zero,
                    want[63:32], want[31:0], want[64]);
            end
            returned[res_tag] = issued[res_tag];
        end
    end

    initial begin : main_sequence
        logic sgn_a, sgn_b;
        srt_div_pkg::data_t a, b, c, d;
        int assert_failures;
        req_valid_1 = 1'b0;
        req_tag_1 = '0;
        req_signed_1 = 1'b0;
        req_dividend_1 = '0;
        req_divisor_1 = '0;
        req_valid_2 = 1'b0;
        req_tag_2 = '0;
        req_signed_2 = 1'b0;
        req_dividend_2 = '0;
        req_divisor_2 = '0;
        apply_reset = 1'b0;
        next_tag = '0;
        wait_reset_release();

        for (int i = 0; i < 40; i++) begin
            random_operands(sgn_a, a, b);
            issue_one(sgn_a, a, b);
        end
        drain();

        // both ports in the same cycle
        for (int i = 0; i < 20; i++) begin
            random_operands(sgn_a, a, b);
            random_operands(sgn_b, c, d);
            issue_requests(1'b1, sgn_a, a, b, sgn_b, c, d);
        end
        drain();

        issue_one(1'b1, 32'h1234_5678, 32'h0);
        issue_one(1'b0, 32'hdead_beef, 32'h0);
        issue_one(1'b1, 32'h8000_0000, 32'hffff_ffff);
        issue_one(1'b0, 32'h8000_0000, 32'hffff_ffff);
        issue_one(1'b1, 32'h0000_0005, 32'h0000_0007);
        issue_one(1'b1, 32'hffff_fffb, 32'h0000_0007);
        issue_one(1'b1, 32'hffff_fff9, 32'h0000_0002);
        issue_one(1'b1, 32'h0000_0007, 32'hffff_fffe);
        issue_one(1'b0, 32'h0000_0000, 32'h0000_0005);
        issue_one(1'b0, 32'h0000_0001, 32'h0000_0001);
        issue_one(1'b0, 32'h0000_00ff, 32'h0000_0003);
        issue_one(1'b1, 32'hffff_ff00, 32'hffff_fff0);
        issue_one(1'b1, 32'hffff_ffff, 32'h0000_0001);
        issue_one(1'b0, 32'hffff_ffff, 32'h0000_0001);
        drain();

        // 32-round divides keep every lane busy
        for (int i = 0; i < `DIV_LANES; i++) begin
            issue_one(1'b0, srt_div_pkg::data_t'(32'hffff_ff00 + i), 32'h1);
        end
        @(negedge clk);
        assert (timed_out || !ready_1) else begin
            check_errors++;
            $display("** Error at %0t ns: ready_1 still high with all lanes busy", $time);
        end
        drain();

        // reset with lanes in flight
        for (int i = 0; i < 3; i++) begin
            issue_one(1'b0, srt_div_pkg::data_t'(32'hffff_0000 + i), 32'h3);
        end
        @(posedge clk);
        apply_reset <= 1'b1;
        repeat (5) @(posedge clk);
        apply_reset <= 1'b0;
        wait_reset_release();
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            assert (ready_1 && ready_2 && !res_valid) else begin
                check_errors++;
                $display("** Error at %0t ns: unit not quiet after reset", $time);
            end
        end
        for (int i = 0; i < 12; i++) begin
            random_operands(sgn_a, a, b);
            issue_one(sgn_a, a, b);
        end
        drain();

        repeat (5) @(posedge clk);
        assert_failures = u_srt_div_unit.u_checker.assert_failures;
        $display("errors: %0d value, %0d check, %0d timeout, %0d assertion; %0d results",
            value_errors, check_errors, timeouts, assert_failures, results_seen);
        if (value_errors + check_errors + timeouts + assert_failures == 0 && results_seen > 0)
        begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/srt_div_checker.sv
// divide unit port assertions
`timescale 1ns/10ps
`default_nettype none
`include "srt_div_macros.svh"

module srt_div_checker (
    input logic                  clk,
    input logic                  reset,
    input logic                  ready_1,
    input logic                  ready_2,
    input logic                  res_valid,
    input srt_div_pkg::tag_t     res_tag,
    input logic [`DIV_LANES-1:0] lane_grant,
    input logic [`DIV_LANES-1:0] lane_idle
);

    int assert_failures = 0;

    // one result per tag, never repeated back to back
    assert property (@(posedge clk) disable iff (reset)
        res_valid && $past(res_valid) |-> res_tag != $past(res_tag))
    else begin
        assert_failures++;
        $error("result tag repeated on consecutive cycles");
    end

    assert property (@(posedge clk) ready_2 |-> ready_1)
    else begin
        assert_failures++;
        $error("ready_2 high while ready_1 is low");
    end

    assert property (@(posedge clk) disable iff (reset) $onehot0(lane_grant))
    else begin
        assert_failures++;
        $error("more than one lane granted");
    end

    // idle is decoded from the lane state
    assert property (@(posedge clk) $fell(reset) |-> &lane_idle)
    else begin
        assert_failures++;
        $error("lane not idle when reset is released");
    end

endmodule

bind srt_div_unit srt_div_checker u_checker (
    .clk        (clk),
    .reset      (reset),
    .ready_1    (ready_1),
    .ready_2    (ready_2),
    .res_valid  (res_valid),
    .res_tag    (res_tag),
    .lane_grant (lane_grant),
    .lane_idle  (lane_idle)
);

`default_nettype wire

// File: dv/tb_clock.sv
// testbench clock and reset
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
    input  logic apply_reset,
    output logic clk,
    output logic reset
);

    localparam int RESET_CYCLES = 10;

    logic por;

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        por = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        por <= 1'b0;
    end

    // later resets come from the test sequence
    assign reset = por | apply_reset;

endmodule

`default_nettype wire

// File: source/srt_div_unit.sv
// multi-lane divide unit
`timescale 1ns/10ps
`default_nettype none
`include "srt_div_macros.svh"

module srt_div_unit (
    input  logic               clk,
    input  logic               reset,
    input  logic               req_valid_1,
    input  srt_div_pkg::tag_t  req_tag_1,
    input  logic               req_signed_1,
    input  srt_div_pkg::data_t req_dividend_1,
    input  srt_div_pkg::data_t req_divisor_1,
    input  logic               req_valid_2,
    input  srt_div_pkg::tag_t  req_tag_2,
    input  logic               req_signed_2,
    input  srt_div_pkg::data_t req_dividend_2,
    input  srt_div_pkg::data_t req_divisor_2,
    output logic               ready_1,
    output logic               ready_2,
    output logic               res_valid,
    output srt_div_pkg::tag_t  res_tag,
    output srt_div_pkg::data_t res_quotient,
    output srt_div_pkg::data_t res_remainder,
    output logic               res_div_zero
);

    logic [`DIV_LANES-1:0] lane_start, lane_idle, lane_signed;
    logic [`DIV_LANES-1:0] lane_done, lane_grant, lane_div_zero;
    srt_div_pkg::tag_t  [`DIV_LANES-1:0] lane_tag, lane_res_tag;
    srt_div_pkg::data_t [`DIV_LANES-1:0] lane_dividend, lane_divisor;
    srt_div_pkg::data_t [`DIV_LANES-1:0] lane_quotient, lane_remainder;

    div_dispatch u_dispatch (
        .clk            (clk),
        .reset          (reset),
        .req_valid_1    (req_valid_1),
        .req_tag_1      (req_tag_1),
        .req_signed_1   (req_signed_1),
        .req_dividend_1 (req_dividend_1),
        .req_divisor_1  (req_divisor_1),
        .req_valid_2    (req_valid_2),
        .req_tag_2      (req_tag_2),
        .req_signed_2   (req_signed_2),
        .req_dividend_2 (req_dividend_2),
        .req_divisor_2  (req_divisor_2),
        .lane_idle      (lane_idle),
        .ready_1        (ready_1),
        .ready_2        (ready_2),
        .lane_start     (lane_start),
        .lane_tag       (lane_tag),
        .lane_signed    (lane_signed),
        .lane_dividend  (lane_dividend),
        .lane_divisor   (lane_divisor)
    );

    for (genvar i = 0; i < `DIV_LANES; i++) begin : g_lane
        srt_lane u_lane (
            .clk       (clk),
            .reset     (reset),
            .start     (lane_start[i]),
            .tag       (lane_tag[i]),
            .is_signed (lane_signed[i]),
            .dividend  (lane_dividend[i]),
            .divisor   (lane_divisor[i]),
            .grant     (lane_grant[i]),
            .idle      (lane_idle[i]),
            .done      (lane_done[i]),
            .res_tag   (lane_res_tag[i]),
            .quotient  (lane_quotient[i]),
            .remainder (lane_remainder[i]),
            .div_zero  (lane_div_zero[i])
        );
    end

    div_collect u_collect (
        .clk            (clk),
        .reset          (reset),
        .lane_done      (lane_done),
        .lane_tag       (lane_res_tag),
        .lane_quotient  (lane_quotient),
        .lane_remainder (lane_remainder),
        .lane_div_zero  (lane_div_zero),
        .lane_grant     (lane_grant),
        .res_valid      (res_valid),
        .res_tag        (res_tag),
        .res_quotient   (res_quotient),
        .res_remainder  (res_remainder),
        .res_div_zero   (res_div_zero)
    );

endmodule

`default_nettype wire

// File: source/div_collect.sv
// divide result collector
`timescale 1ns/10ps
`default_nettype none
`include "srt_div_macros.svh"

module div_collect (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [`DIV_LANES-1:0]               lane_done,
    input  srt_div_pkg::tag_t  [`DIV_LANES-1:0] lane_tag,
    input  srt_div_pkg::data_t [`DIV_LANES-1:0] lane_quotient,
    input  srt_div_pkg::data_t [`DIV_LANES-1:0] lane_remainder,
    input  logic [`DIV_LANES-1:0]               lane_div_zero,
    output logic [`DIV_LANES-1:0]               lane_grant,
    output logic                                res_valid,
    output srt_div_pkg::tag_t                   res_tag,
    output srt_div_pkg::data_t                  res_quotient,
    output srt_div_pkg::data_t                  res_remainder,
    output logic                                res_div_zero
);

    // lowest-index done lane wins
    assign lane_grant = lane_done & (~lane_done + 1'b1);

    always_ff @(posedge clk) begin
        if (reset) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= |lane_done;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `DIV_LANES; i++) begin
            if (lane_grant[i]) begin
                res_tag <= lane_tag[i];
                res_quotient <= lane_quotient[i];
                res_remainder <= lane_remainder[i];
                res_div_zero <= lane_div_zero[i];
            end
        end
    end

endmodule

`default_nettype wire

// File: source/div_dispatch.sv
// divide request dispatcher
`timescale 1ns/10ps
`default_nettype none
`include "srt_div_macros.svh"

module div_dispatch (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                req_valid_1,
    input  srt_div_pkg::tag_t                   req_tag_1,
    input  logic                                req_signed_1,
    input  srt_div_pkg::data_t                  req_dividend_1,
    input  srt_div_pkg::data_t                  req_divisor_1,
    input  logic                                req_valid_2,
    input  srt_div_pkg::tag_t                   req_tag_2,
    input  logic                                req_signed_2,
    input  srt_div_pkg::data_t                  req_dividend_2,
    input  srt_div_pkg::data_t                  req_divisor_2,
    input  logic [`DIV_LANES-1:0]               lane_idle,
    output logic                                ready_1,
    output logic                                ready_2,
    output logic [`DIV_LANES-1:0]               lane_start,
    output srt_div_pkg::tag_t  [`DIV_LANES-1:0] lane_tag,
    output logic [`DIV_LANES-1:0]               lane_signed,
    output srt_div_pkg::data_t [`DIV_LANES-1:0] lane_dividend,
    output srt_div_pkg::data_t [`DIV_LANES-1:0] lane_divisor
);

    localparam int CNT_WIDTH = $clog2(`DIV_LANES + 1);

    logic [CNT_WIDTH-1:0] idle_count, idle_count_next;
    logic [`DIV_LANES-1:0] avail, rest, first_oh, second_oh;
    logic [`DIV_LANES-1:0] sel_1, sel_2, start_next;
    logic accept_1, accept_2;

    assign ready_1 = idle_count != '0;
    assign ready_2 = idle_count >= CNT_WIDTH'(2);

    always_comb begin
        // a started lane still shows idle for one cycle
        avail = lane_idle & ~lane_start;
        first_oh = avail & (~avail + 1'b1);
        rest = avail & ~first_oh;
        second_oh = rest & (~rest + 1'b1);
        accept_1 = req_valid_1 && ready_1;
        accept_2 = req_valid_2 && (req_valid_1 ? ready_2 : ready_1);
        sel_1 = accept_1 ? first_oh : '0;
        sel_2 = '0;
        if (accept_2) begin
            sel_2 = accept_1 ? second_oh : first_oh;
        end
        start_next = sel_1 | sel_2;
        // lanes freed by a grant are counted a cycle late
        idle_count_next = '0;
        for (int i = 0; i < `DIV_LANES; i++) begin
            idle_count_next = idle_count_next + CNT_WIDTH'(avail[i] & ~start_next[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lane_start <= '0;
            idle_count <= CNT_WIDTH'(`DIV_LANES);
        end else begin
            lane_start <= start_next;
            idle_count <= idle_count_next;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `DIV_LANES; i++) begin
            if (sel_1[i]) begin
                lane_tag[i] <= req_tag_1;
                lane_signed[i] <= req_signed_1;
                lane_dividend[i] <= req_dividend_1;
                lane_divisor[i] <= req_divisor_1;
            end else if (sel_2[i]) begin
                lane_tag[i] <= req_tag_2;
                lane_signed[i] <= req_signed_2;
                lane_dividend[i] <= req_dividend_2;
                lane_divisor[i] <= req_divisor_2;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/srt_lane.sv
// radix-2 srt divider lane
`timescale 1ns/10ps
`default_nettype none
`include "srt_div_macros.svh"

module srt_lane (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  srt_div_pkg::tag_t  tag,
    input  logic               is_signed,
    input  srt_div_pkg::data_t dividend,
    input  srt_div_pkg::data_t divisor,
    input  logic               grant,
    output logic               idle,
    output logic               done,
    output srt_div_pkg::tag_t  res_tag,
    output srt_div_pkg::data_t quotient,
    output srt_div_pkg::data_t remainder,
    output logic               div_zero
);

    srt_div_pkg::lane_state_t state;

    // partial remainder and divisor with a sign bit on top
    logic [`DIV_WIDTH:0] s;
    logic [`DIV_WIDTH:0] d;
    logic [`DIV_WIDTH:0] s_step;
    logic [`DIV_WIDTH:0] s_fix;
    srt_div_pkg::data_t pos_q, neg_q, dividend_q, q_mag, r_mag;
    logic [`LZC_WIDTH-1:0] s_zero, d_zero, counter, rounds, d_shift;
    logic x_neg, y_neg, q_neg, r_neg;
    logic digit_pos, digit_neg;

    assign x_neg = is_signed & dividend[`DIV_WIDTH-1];
    assign y_neg = is_signed & divisor[`DIV_WIDTH-1];
    assign idle  = state == srt_div_pkg::LANE_IDLE;
    assign done  = state == srt_div_pkg::LANE_HOLD;

    lead_zero_count u_lzc_s (.data(s[`DIV_WIDTH-1:0]), .zero_count(s_zero));
    lead_zero_count u_lzc_d (.data(d[`DIV_WIDTH-1:0]), .zero_count(d_zero));

    always_comb begin
        digit_pos = 1'b0;
        digit_neg = 1'b0;
        s_step = s;
        // digit from the top two bits of the partial remainder
        case (s[`DIV_WIDTH:`DIV_WIDTH-1])
            2'b01: begin
                digit_pos = 1'b1;
                s_step = s - d;
            end
            2'b10: begin
                digit_neg = 1'b1;
                s_step = s + d;
            end
            default: ;
        endcase
        // negative final remainder means the quotient is one ulp high
        s_fix = s[`DIV_WIDTH] ? s + d : s;
        q_mag = pos_q - neg_q - srt_div_pkg::data_t'(s[`DIV_WIDTH]);
        r_mag = srt_div_pkg::data_t'(s_fix >> d_shift);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= srt_div_pkg::LANE_IDLE;
            counter <= '0;
        end else begin
            case (state)
                srt_div_pkg::LANE_IDLE: begin
                    if (start) begin
                        state <= srt_div_pkg::LANE_NORMALIZE;
                    end
                end
                srt_div_pkg::LANE_NORMALIZE: begin
                    counter <= '0;
                    if (d_zero == `DIV_WIDTH || d_zero < s_zero) begin
                        state <= srt_div_pkg::LANE_HOLD;
                    end else begin
                        state <= srt_div_pkg::LANE_ITERATE;
                    end
                end
                srt_div_pkg::LANE_ITERATE: begin
                    counter <= counter + 1'b1;
                    if (counter == rounds) begin
                        state <= srt_div_pkg::LANE_FINISH;
                    end
                end
                srt_div_pkg::LANE_FINISH: begin
                    state <= srt_div_pkg::LANE_HOLD;
                end
                srt_div_pkg::LANE_HOLD: begin
                    if (grant) begin
                        state <= srt_div_pkg::LANE_IDLE;
                    end
                end
                default: begin
                    state <= srt_div_pkg::LANE_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            srt_div_pkg::LANE_IDLE: begin
                if (start) begin
                    s <= {1'b0, x_neg ? -dividend : dividend};
                    d <= {1'b0, y_neg ? -divisor : divisor};
                    q_neg <= x_neg ^ y_neg;
                    r_neg <= x_neg;
                    dividend_q <= dividend;
                    res_tag <= tag;
                    pos_q <= '0;
                    neg_q <= '0;
                end
            end
            srt_div_pkg::LANE_NORMALIZE: begin
                if (d_zero == `DIV_WIDTH) begin
                    quotient <= '1;
                    remainder <= dividend_q;
                    div_zero <= 1'b1;
                end else if (d_zero < s_zero) begin
                    // divisor larger than dividend
                    quotient <= '0;
                    remainder <= dividend_q;
                    div_zero <= 1'b0;
                end else begin
                    s <= {1'b0, s[`DIV_WIDTH-1:0] << s_zero};
                    d <= {1'b0, d[`DIV_WIDTH-1:0] << d_zero};
                    rounds <= d_zero - s_zero;
                    d_shift <= d_zero;
                end
            end
            srt_div_pkg::LANE_ITERATE: begin
                pos_q <= {pos_q[`DIV_WIDTH-2:0], digit_pos};
                neg_q <= {neg_q[`DIV_WIDTH-2:0], digit_neg};
                // last digit is not shifted
                s <= (counter == rounds) ? s_step : {s_step[`DIV_WIDTH-1:0], 1'b0};
            end
            srt_div_pkg::LANE_FINISH: begin
                // most negative by minus one wraps back to the dividend here
                quotient <= q_neg ? -q_mag : q_mag;
                remainder <= r_neg ? -r_mag : r_mag;
                div_zero <= 1'b0;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: source/lead_zero_count.sv
// leading zero counter
`timescale 1ns/10ps
`default_nettype none
`include "srt_div_macros.svh"

module lead_zero_count (
    input  srt_div_pkg::data_t    data,
    output logic [`LZC_WIDTH-1:0] zero_count
);

    srt_div_pkg::data_t x;

    always_comb begin
        x = data;
        zero_count = '0;
        if (data == '0) begin
            // all zeros gives 32
            zero_count[`LZC_WIDTH-1] = 1'b1;
        end else begin
            // halve the search window each level
            if (x[31:16] == '0) begin
                zero_count[4] = 1'b1;
                x = x << 16;
            end
            if (x[31:24] == '0) begin
                zero_count[3] = 1'b1;
                x = x << 8;
            end
            if (x[31:28] == '0) begin
                zero_count[2] = 1'b1;
                x = x << 4;
            end
            if (x[31:30] == '0) begin
                zero_count[1] = 1'b1;
                x = x << 2;
            end
            if (!x[31]) begin
                zero_count[0] = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/srt_div_pkg.sv
// divide unit types
`default_nettype none
`include "srt_div_macros.svh"

package srt_div_pkg;

    // lane FSM
    typedef enum logic [2:0] {
        LANE_IDLE      = 3'd0,
        LANE_NORMALIZE = 3'd1,
        LANE_ITERATE   = 3'd2,
        LANE_FINISH    = 3'd3,
        LANE_HOLD      = 3'd4
    } lane_state_t;

    typedef logic [`TAG_WIDTH-1:0] tag_t;

    // operand or result word
    typedef logic [`DIV_WIDTH-1:0] data_t;

endpackage

`default_nettype wire

// File: source/srt_div_macros.svh
// divide unit constants
`ifndef SRT_DIV_MACROS_SVH
`define SRT_DIV_MACROS_SVH

// operand and result word
`define DIV_WIDTH 32

// divider lanes behind the two issue ports
`define DIV_LANES 4

`define TAG_WIDTH 4

// leading-zero count runs 0 to 32
`define LZC_WIDTH 6

`endif
